// ==== verilog.f ====
hw/rvc_pkg.sv
hw/rvc_quadrant0.sv
hw/rvc_quadrant1.sv
hw/rvc_quadrant2.sv
hw/rvc_expander.sv
bench/tb_clk_rst.sv
bench/tb_rvc_expander.sv

// ==== Bender.yml ====
package:
  name: rvc_expander

sources:
  - files:
      - hw/rvc_pkg.sv
      - hw/rvc_quadrant0.sv
      - hw/rvc_quadrant1.sv
      - hw/rvc_quadrant2.sv
      - hw/rvc_expander.sv
  - target: test
    files:
      - bench/tb_clk_rst.sv
      - bench/tb_rvc_expander.sv

// ==== bench/tb_rvc_expander.sv ====
//////////////////////////////
// testbench for the RV32C expander
// streams a table of hand-expanded words back to back,
// then random full-width words, checking one-cycle latency
//////////////////////////////

`timescale 1ns/10ps

module tb_rvc_expander import rvc_pkg::*;;

  localparam int MAX_VEC    = 40;
  localparam int WAIT_LIMIT = 20;
  localparam int NUM_RANDOM = 200;

  logic  clk, arst_n, valid, valid_out, compressed, illegal;
  word_t instr_in, instr_out;

  // stimulus table with one entry per applied word
  string vec_name [MAX_VEC];
  word_t vec_in   [MAX_VEC];
  word_t vec_exp  [MAX_VEC];
  logic  vec_comp [MAX_VEC];
  logic  vec_ill  [MAX_VEC];
  int    vec_count;

  tb_clk_rst u_clk_rst (.clk_o(clk), .arst_n_o(arst_n));

  rvc_expander uut (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .valid_i        (valid),
    .instr_i        (instr_in),
    .valid_o        (valid_out),
    .instr_o        (instr_out),
    .is_compressed_o(compressed),
    .illegal_instr_o(illegal)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input word_t expected, input word_t actual);
    assert (actual === expected) else begin
      report_failure($sformatf("[FAIL] %s expected %08h actual %08h", name, expected, actual));
    end
  endtask

  function automatic word_t xorshift32(input word_t state);
    word_t x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // valid_o must rise after exactly one edge
  task automatic await_result(input string name);
    int cycles;
    cycles = 0;
    do begin
      next_cycle();
      cycles++;
    end while (!valid_out && cycles < WAIT_LIMIT);
    assert (valid_out) else report_failure({"timeout waiting for valid_o after ", name});
    assert (cycles == 1) else report_failure({"result of ", name, " arrived late"});
  endtask

  task automatic check_idle_outputs(input string tag);
    compare_value({tag, " valid_o"}, 32'd0, valid_out);
    compare_value({tag, " instr_o"}, 32'd0, instr_out);
    compare_value({tag, " is_compressed_o"}, 32'd0, compressed);
    compare_value({tag, " illegal_instr_o"}, 32'd0, illegal);
  endtask

  task automatic add_vector(input string name, input word_t in_word, input word_t exp_word,
                            input logic comp, input logic ill);
    vec_name[vec_count] = name;
    vec_in[vec_count]   = in_word;
    vec_exp[vec_count]  = exp_word;
    vec_comp[vec_count] = comp;
    vec_ill[vec_count]  = ill;
    vec_count++;
  endtask

  // each entry holds name, fetch word, expected word and the two flags
  // the word of an illegal entry is not compared
  task automatic load_vectors();
    add_vector("c.addi4spn x8,4",  32'h0000_0040, 32'h0041_0413, 1'b1, 1'b0);
    add_vector("c.lw x9,4(x10)",   32'h0000_4144, 32'h0045_2483, 1'b1, 1'b0);
    add_vector("c.sw x9,8(x10)",   32'h0000_c504, 32'h0095_2423, 1'b1, 1'b0);
    add_vector("c.addi x10,-1",    32'h0000_157d, 32'hfff5_0513, 1'b1, 1'b0);
    add_vector("c.li x11,5",       32'h0000_4595, 32'h0050_0593, 1'b1, 1'b0);
    add_vector("c.lui x12,1",      32'h0000_6605, 32'h0000_1637, 1'b1, 1'b0);
    add_vector("c.addi16sp 16",    32'h0000_6141, 32'h0101_0113, 1'b1, 1'b0);
    add_vector("c.jal 8",          32'h0000_2021, 32'h0080_00ef, 1'b1, 1'b0);
    add_vector("c.beqz x8,8",      32'h0000_c401, 32'h0004_0463, 1'b1, 1'b0);
    add_vector("c.srli x8,3",      32'h0000_800d, 32'h0034_5413, 1'b1, 1'b0);
    add_vector("c.andi x10,-4",    32'h0000_9971, 32'hffc5_7513, 1'b1, 1'b0);
    add_vector("c.sub x8,x9",      32'h0000_8c05, 32'h4094_0433, 1'b1, 1'b0);
    add_vector("c.xor x10,x11",    32'h0000_8d2d, 32'h00b5_4533, 1'b1, 1'b0);
    add_vector("c.and x14,x15",    32'h0000_8f7d, 32'h00f7_7733, 1'b1, 1'b0);
    add_vector("c.slli x10,2",     32'h0000_050a, 32'h0025_1513, 1'b1, 1'b0);
    add_vector("c.lwsp x11,8",     32'h0000_45a2, 32'h0081_2583, 1'b1, 1'b0);
    add_vector("c.swsp x12,12",    32'h0000_c632, 32'h00c1_2623, 1'b1, 1'b0);
    add_vector("c.jr x1",          32'h0000_8082, 32'h0000_8067, 1'b1, 1'b0);
    add_vector("c.mv x10,x11",     32'h0000_852e, 32'h00b0_0533, 1'b1, 1'b0);
    add_vector("c.ebreak",         32'h0000_9002, 32'h0010_0073, 1'b1, 1'b0);
    add_vector("c.add x10,x11",    32'h0000_952e, 32'h00b5_0533, 1'b1, 1'b0);
    add_vector("full add",         32'h00b5_0533, 32'h00b5_0533, 1'b0, 1'b0);
    add_vector("addi4spn zero",    32'h0000_0000, 32'h0000_0000, 1'b1, 1'b1);
    add_vector("c.lui zero",       32'h0000_6601, 32'h0000_0000, 1'b1, 1'b1);
    add_vector("c.lwsp x0",        32'h0000_4022, 32'h0000_0000, 1'b1, 1'b1);
    add_vector("c.jr x0",          32'h0000_8002, 32'h0000_0000, 1'b1, 1'b1);
    add_vector("c.slli bit12",     32'h0000_150a, 32'h0000_0000, 1'b1, 1'b1);
    add_vector("c.srli bit12",     32'h0000_900d, 32'h0000_0000, 1'b1, 1'b1);
    add_vector("zc c0 slot",       32'h0000_8000, 32'h0000_0000, 1'b1, 1'b1);
    add_vector("zc c.mul slot",    32'h0000_9c45, 32'h0000_0000, 1'b1, 1'b1);
    add_vector("c.flw slot",       32'h0000_6000, 32'h0000_0000, 1'b1, 1'b1);
    add_vector("c.fswsp slot",     32'h0000_e002, 32'h0000_0000, 1'b1, 1'b1);
  endtask

  initial begin
    word_t rnd;
    word_t held_word;
    logic  held_comp;
    logic  held_ill;
    int    guard;
    valid       = 1'b0;
    instr_in    = '0;
    vec_count   = 0;
    rnd         = 32'd70894;
    load_vectors();

    next_cycle();
    check_idle_outputs("in reset");
    guard = 0;
    while (!arst_n && guard < WAIT_LIMIT) begin
      @(posedge clk);
      guard++;
    end
    assert (arst_n) else report_failure("reset was never released");
    next_cycle();
    check_idle_outputs("after reset");

    //////////////////////////////
    // table stream back to back
    //////////////////////////////

    for (int i = 0; i < vec_count; i++) begin
      valid    = 1'b1;
      instr_in = vec_in[i];
      await_result(vec_name[i]);
      if (!vec_ill[i]) compare_value(vec_name[i], vec_exp[i], instr_out);
      compare_value({vec_name[i], " compressed"}, vec_comp[i], compressed);
      compare_value({vec_name[i], " illegal"}, vec_ill[i], illegal);
    end

    // data must hold through a bubble
    held_word = instr_out;
    held_comp = compressed;
    held_ill  = illegal;
    valid     = 1'b0;
    instr_in  = 32'h0000_8082;
    next_cycle();
    compare_value("bubble valid_o", 32'd0, valid_out);
    compare_value("bubble instr_o", held_word, instr_out);
    compare_value("bubble is_compressed_o", held_comp, compressed);
    compare_value("bubble illegal_instr_o", held_ill, illegal);

    //////////////////////////////
    // random full-width words
    //////////////////////////////

    for (int n = 0; n < NUM_RANDOM; n++) begin
      rnd      = xorshift32(rnd);
      valid    = 1'b1;
      instr_in = {rnd[31:2], QUAD_FULL};
      await_result($sformatf("random %0d", n));
      compare_value($sformatf("random %0d word", n), instr_in, instr_out);
      compare_value($sformatf("random %0d compressed", n), 32'd0, compressed);
      compare_value($sformatf("random %0d illegal", n), 32'd0, illegal);
    end
    valid = 1'b0;

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// ==== bench/tb_clk_rst.sv ====
//////////////////////////////
// testbench clock and reset source
// 10 ns clock, reset held low for the first 3 rising edges
//////////////////////////////

`timescale 1ns/10ps

module tb_clk_rst (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // release just after the third edge
  initial begin
    arst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #1 arst_n_o = 1'b1;
  end

endmodule

// ==== hw/rvc_expander.sv ====
//////////////////////////////
// RV32C expander, fetch to decode boundary
// picks the quadrant result or passes a full word through
// and registers it one cycle later, qualified by valid_i
//////////////////////////////

`timescale 1ns/10ps

module rvc_expander import rvc_pkg::*; (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  valid_i,
  input  word_t instr_i,
  output logic  valid_o,
  output word_t instr_o,
  output logic  is_compressed_o,
  output logic  illegal_instr_o
);

  word_t q0_instr, q1_instr, q2_instr;
  logic  q0_illegal, q1_illegal, q2_illegal;
  word_t exp_instr;
  logic  exp_illegal;
  logic  exp_compressed;

  rvc_quadrant0 u_quad0 (.instr_i(instr_i[15:0]), .instr_o(q0_instr), .illegal_o(q0_illegal));
  rvc_quadrant1 u_quad1 (.instr_i(instr_i[15:0]), .instr_o(q1_instr), .illegal_o(q1_illegal));
  rvc_quadrant2 u_quad2 (.instr_i(instr_i[15:0]), .instr_o(q2_instr), .illegal_o(q2_illegal));

  //////////////////////////////
  // quadrant select
  //////////////////////////////

  assign exp_compressed = (instr_i[1:0] != QUAD_FULL);

  always_comb begin
    case (instr_i[1:0])
      QUAD_C0: begin
        exp_instr   = q0_instr;
        exp_illegal = q0_illegal;
      end
      QUAD_C1: begin
        exp_instr   = q1_instr;
        exp_illegal = q1_illegal;
      end
      QUAD_C2: begin
        exp_instr   = q2_instr;
        exp_illegal = q2_illegal;
      end
      default: begin
        // full width word goes through untouched
        exp_instr   = instr_i;
        exp_illegal = 1'b0;
      end
    endcase
  end

  //////////////////////////////
  // decode stage register
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o         <= 1'b0;
      instr_o         <= '0;
      is_compressed_o <= 1'b0;
      illegal_instr_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
      // data holds while no word arrives
      if (valid_i) begin
        instr_o         <= exp_instr;
        is_compressed_o <= exp_compressed;
        illegal_instr_o <= exp_illegal;
      end
    end
  end

  // a full width word is never flagged by any quadrant
  a_illegal_only_compressed: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) illegal_instr_o |-> is_compressed_o
  ) else $error("illegal_instr_o set on a full width word");

  a_no_valid_in_reset: assert property (
    @(posedge clk_i) !arst_n_i |-> !valid_o
  ) else $error("valid_o high during reset");

endmodule

// ==== hw/rvc_quadrant2.sv ====
//////////////////////////////
// RV32C quadrant C2 expansion
// shifts, stack pointer access, moves, register jumps, ebreak
// purely combinational
//////////////////////////////

`timescale 1ns/10ps

module rvc_quadrant2 import rvc_pkg::*; (
  input  c_instr_t instr_i,
  output word_t    instr_o,
  output logic     illegal_o
);

  logic [4:0] rd;
  logic [4:0] rs2;
  word_t      lwsp_word;

  // rd doubles as rs1 in this quadrant
  assign rd  = instr_i[11:7];
  assign rs2 = instr_i[6:2];

  // c.lwsp -> lw rd, uimm(sp)
  assign lwsp_word = {4'b0, instr_i[3:2], instr_i[12], instr_i[6:4], 2'b00,
                      REG_SP, FUNCT3_W, rd, OPCODE_LOAD};

  always_comb begin
    instr_o   = lwsp_word;
    illegal_o = 1'b0;

    case (instr_i[15:13])
      3'b000: begin
        // c.slli -> slli rd, rd, shamt
        instr_o = {7'b0, rs2, rd, FUNCT3_SLL, rd, OPCODE_OPIMM};
        if (instr_i[12]) begin
          illegal_o = 1'b1;
        end
      end
      3'b010: begin
        instr_o = lwsp_word;
        if (rd == REG_ZERO) begin
          illegal_o = 1'b1;
        end
      end
      3'b100: begin
        if (!instr_i[12]) begin
          if (rs2 == REG_ZERO) begin
            // c.jr -> jalr x0, 0(rs1), rs1 of x0 is reserved
            instr_o = {12'b0, rd, FUNCT3_ADD, REG_ZERO, OPCODE_JALR};
            if (rd == REG_ZERO) begin
              illegal_o = 1'b1;
            end
          end else begin
            // c.mv -> add rd, x0, rs2
            instr_o = {7'b0, rs2, REG_ZERO, FUNCT3_ADD, rd, OPCODE_OP};
          end
        end else if (rs2 == REG_ZERO) begin
          if (rd == REG_ZERO) begin
            instr_o = EBREAK_WORD;
          end else begin
            // c.jalr -> jalr ra, 0(rs1)
            instr_o = {12'b0, rd, FUNCT3_ADD, REG_RA, OPCODE_JALR};
          end
        end else begin
          // c.add -> add rd, rd, rs2
          instr_o = {7'b0, rs2, rd, FUNCT3_ADD, rd, OPCODE_OP};
        end
      end
      3'b110: begin
        // c.swsp -> sw rs2, uimm(sp)
        instr_o = {4'b0, instr_i[8:7], instr_i[12], rs2, REG_SP, FUNCT3_W,
                   instr_i[11:9], 2'b00, OPCODE_STORE};
      end
      default: begin
        // float, table jump and zc slots
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

// ==== hw/rvc_quadrant1.sv ====
//////////////////////////////
// RV32C quadrant C1 expansion
// immediates, jumps, register-prime arithmetic and branches
// combinational, every immediate sign extends from bit 12
//////////////////////////////

`timescale 1ns/10ps

module rvc_quadrant1 import rvc_pkg::*; (
  input  c_instr_t instr_i,
  output word_t    instr_o,
  output logic     illegal_o
);

  logic [4:0] rd;
  logic [4:0] rs1_p;
  logic [4:0] rs2_p;
  logic       sign;
  word_t      and_word;

  assign rd    = instr_i[11:7];
  assign rs1_p = {PRIME_PREFIX, instr_i[9:7]};
  assign rs2_p = {PRIME_PREFIX, instr_i[4:2]};
  assign sign  = instr_i[12];

  // c.and form, also the filler for the reserved arithmetic slots
  assign and_word = {7'b0, rs2_p, rs1_p, FUNCT3_AND, rs1_p, OPCODE_OP};

  always_comb begin
    instr_o   = and_word;
    illegal_o = 1'b0;

    case (instr_i[15:13])
      3'b000: begin
        // c.addi -> addi rd, rd, imm (c.nop when rd is x0)
        instr_o = {{6{sign}}, sign, instr_i[6:2], rd, FUNCT3_ADD, rd, OPCODE_OPIMM};
      end
      3'b001, 3'b101: begin
        // c.jal links through ra, c.j discards the link
        instr_o = {sign, instr_i[8], instr_i[10:9], instr_i[6], instr_i[7], instr_i[2],
                   instr_i[11], instr_i[5:3], {9{sign}},
                   (instr_i[15] ? REG_ZERO : REG_RA), OPCODE_JAL};
      end
      3'b010: begin
        // c.li -> addi rd, x0, imm
        instr_o = {{6{sign}}, sign, instr_i[6:2], REG_ZERO, FUNCT3_ADD, rd, OPCODE_OPIMM};
      end
      3'b011: begin
        if (rd == REG_SP) begin
          // c.addi16sp -> addi sp, sp, nzimm*16
          instr_o = {{3{sign}}, instr_i[4:3], instr_i[5], instr_i[2], instr_i[6], 4'b0,
                     REG_SP, FUNCT3_ADD, REG_SP, OPCODE_OPIMM};
        end else begin
          // c.lui -> lui rd, nzimm
          instr_o = {{15{sign}}, instr_i[6:2], rd, OPCODE_LUI};
        end
        // zero immediate is reserved for both forms
        if ({sign, instr_i[6:2]} == 6'b0) begin
          illegal_o = 1'b1;
        end
      end
      3'b100: begin
        case (instr_i[11:10])
          2'b00, 2'b01: begin
            // c.srli / c.srai, bit 10 selects the arithmetic shift
            instr_o = {1'b0, instr_i[10], 5'b0, instr_i[6:2], rs1_p, FUNCT3_SR, rs1_p,
                       OPCODE_OPIMM};
            // shamt[5] set is RV64 only
            if (sign) begin
              illegal_o = 1'b1;
            end
          end
          2'b10: begin
            // c.andi -> andi rd', rd', imm
            instr_o = {{6{sign}}, sign, instr_i[6:2], rs1_p, FUNCT3_AND, rs1_p, OPCODE_OPIMM};
          end
          default: begin
            case ({sign, instr_i[6:5]})
              3'b000: instr_o = {7'b0100000, rs2_p, rs1_p, FUNCT3_ADD, rs1_p, OPCODE_OP};
              3'b001: instr_o = {7'b0, rs2_p, rs1_p, FUNCT3_XOR, rs1_p, OPCODE_OP};
              3'b010: instr_o = {7'b0, rs2_p, rs1_p, FUNCT3_OR, rs1_p, OPCODE_OP};
              3'b011: instr_o = and_word;
              // subw/addw and the zc slots
              default: illegal_o = 1'b1;
            endcase
          end
        endcase
      end
      default: begin
        // c.beqz / c.bnez -> beq/bne rs1', x0, imm
        instr_o = {{4{sign}}, instr_i[6:5], instr_i[2], REG_ZERO, rs1_p,
                   (instr_i[13] ? FUNCT3_BNE : FUNCT3_BEQ),
                   instr_i[11:10], instr_i[4:3], sign, OPCODE_BRANCH};
      end
    endcase
  end

endmodule

// ==== hw/rvc_quadrant0.sv ====
//////////////////////////////
// RV32C quadrant C0 expansion
// combinational, takes the low half of the fetch word
// covers c.addi4spn, c.lw and c.sw, all other slots illegal
//////////////////////////////

`timescale 1ns/10ps

module rvc_quadrant0 import rvc_pkg::*; (
  input  c_instr_t instr_i,
  output word_t    instr_o,
  output logic     illegal_o
);

  logic [4:0] rd_p;
  logic [4:0] rs1_p;
  logic [4:0] rs2_p;
  word_t      lw_word;

  // register-prime fields
  assign rd_p  = {PRIME_PREFIX, instr_i[4:2]};
  assign rs2_p = {PRIME_PREFIX, instr_i[4:2]};
  assign rs1_p = {PRIME_PREFIX, instr_i[9:7]};

  // c.lw -> lw rd', uimm(rs1'), offset is word scaled
  assign lw_word = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00,
                    rs1_p, FUNCT3_W, rd_p, OPCODE_LOAD};

  always_comb begin
    instr_o   = lw_word;
    illegal_o = 1'b0;

    case (instr_i[15:13])
      3'b000: begin
        // c.addi4spn -> addi rd', sp, nzuimm
        instr_o = {2'b0, instr_i[10:7], instr_i[12:11], instr_i[5], instr_i[6], 2'b00,
                   REG_SP, FUNCT3_ADD, rd_p, OPCODE_OPIMM};
        // zero immediate is reserved
        if (instr_i[12:5] == 8'b0) begin
          illegal_o = 1'b1;
        end
      end
      3'b010: begin
        instr_o = lw_word;
      end
      3'b110: begin
        // c.sw -> sw rs2', uimm(rs1')
        instr_o = {5'b0, instr_i[5], instr_i[12], rs2_p, rs1_p, FUNCT3_W,
                   instr_i[11:10], instr_i[6], 2'b00, OPCODE_STORE};
      end
      default: begin
        // zc loads/stores and float slots, not supported
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

// ==== hw/rvc_pkg.sv ====
//////////////////////////////
// shared definitions for the RV32C expander
// opcodes, register numbers, quadrant codes and word types
// imported with a wildcard import by every RTL module
//////////////////////////////

package rvc_pkg;

  // word types
  typedef logic [31:0] word_t;
  typedef logic [15:0] c_instr_t;
  typedef logic [6:0]  opcode_t;

  //////////////////////////////
  // RV32I major opcodes
  //////////////////////////////

  localparam opcode_t OPCODE_OPIMM  = 7'h13;
  localparam opcode_t OPCODE_OP     = 7'h33;
  localparam opcode_t OPCODE_LUI    = 7'h37;
  localparam opcode_t OPCODE_LOAD   = 7'h03;
  localparam opcode_t OPCODE_STORE  = 7'h23;
  localparam opcode_t OPCODE_JAL    = 7'h6f;
  localparam opcode_t OPCODE_JALR   = 7'h67;
  localparam opcode_t OPCODE_BRANCH = 7'h63;

  // low two bits of the fetch word
  localparam logic [1:0] QUAD_C0   = 2'b00;
  localparam logic [1:0] QUAD_C1   = 2'b01;
  localparam logic [1:0] QUAD_C2   = 2'b10;
  localparam logic [1:0] QUAD_FULL = 2'b11;

  // fixed register numbers
  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA   = 5'd1;
  localparam logic [4:0] REG_SP   = 5'd2;

  // rd', rs1' and rs2' map onto x8..x15
  localparam logic [1:0] PRIME_PREFIX = 2'b01;

  //////////////////////////////
  // funct3 values
  //////////////////////////////

  localparam logic [2:0] FUNCT3_ADD = 3'b000;
  localparam logic [2:0] FUNCT3_SLL = 3'b001;
  localparam logic [2:0] FUNCT3_SR  = 3'b101;
  localparam logic [2:0] FUNCT3_XOR = 3'b100;
  localparam logic [2:0] FUNCT3_OR  = 3'b110;
  localparam logic [2:0] FUNCT3_AND = 3'b111;
  // load and store word
  localparam logic [2:0] FUNCT3_W   = 3'b010;
  // branches against x0
  localparam logic [2:0] FUNCT3_BEQ = 3'b000;
  localparam logic [2:0] FUNCT3_BNE = 3'b001;

  // ebreak, the only fixed 32-bit result
  localparam word_t EBREAK_WORD = 32'h0010_0073;

endpackage
